/* flist.f */
+incdir+source
source/soc_pkg.sv
source/bus_decode.sv
source/ram_store.sv
source/io_regs.sv
source/tick_timer.sv
source/soc_top.sv
test/soc_chk.sv
test/soc_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the SoC memory and IO testbench with Verilator
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
      --top-module soc_tb -f flist.f -o soc_sim; then
   echo "Verilator build failed"
   exit 1
fi

out=$(./obj_dir/soc_sim 2>&1)
status=$?
echo "$out"
if [ "$status" -ne 0 ]; then
   echo "Simulation exited with status $status"
   exit 1
fi

if echo "$out" | grep -q "All checks passed"; then
   exit 0
fi
echo "Pass message not found in simulation output"
exit 1

/* source/bus_decode.sv */
// Region decode and read-data select
module bus_decode (
   input  logic              clk,
   input  logic              mem_rstrb,
   input  soc_pkg::bus_req_t bus_i,
   input  logic [31:0]       ram_rdata_i,
   input  logic [31:0]       io_rdata_i,
   output logic              ram_sel_o,
   output logic              io_sel_o,
   output logic [31:0]       rdata_o
);
   import soc_pkg::*;

   region_t region;      // Region of the current cycle
   region_t rd_region_q; // Region of the last read

   assign region = region_t'(bus_i.addr[31:30]);

   // Selects go straight to the slaves
   assign ram_sel_o = (region == region_ram);
   assign io_sel_o  = (region == region_io);

   // Remember where the read went, so the data stays put until the next read
   always_ff @(posedge clk)
   begin
      if (mem_rstrb)
      begin
         rd_region_q <= region_ram;
      end
      else if (bus_i.rd)
      begin
         rd_region_q <= region;
      end
   end

   // Slaves already hold their registered data
   always_comb
   begin
      case (rd_region_q)
         region_ram:
         begin
            rdata_o = ram_rdata_i;
         end
         region_io:
         begin
            rdata_o = io_rdata_i;
         end
         default:
         begin
            rdata_o = '0; // Flash and SDRAM not fitted
         end
      endcase
   end

endmodule

/* source/io_regs.sv */
// IO page registers
// GPIO, LEDs, buttons, DAC and timer readback
`include "soc_cfg.svh"

module io_regs (
   input  logic                  clk,
   input  logic                  mem_rstrb,
   input  soc_pkg::bus_req_t     bus_i,
   input  logic                  io_sel_i,
   input  logic [`GPIO_IN_W-1:0] gpio_in_i,
   input  logic [`BUTTONS_W-1:0] buttons_i,
   input  logic [31:0]           ticks_i,
   input  logic [31:0]           reload_i,
   output soc_pkg::gpio_t        gpio_o,
   output logic [7:0]            led_o,
   output soc_pkg::analog_t      analog_o,
   output logic [31:0]           rdata_o
);
   import soc_pkg::*;

   logic [31:0] io_rdata; // OR of every addressed register
   logic [31:0] io_mod;   // Write data after modifier
   logic [1:0]  mod_code;
   logic        io_wr;
   logic        io_rd;

   assign mod_code = bus_i.addr[3:2];
   assign io_wr    = io_sel_i & (|bus_i.wmask);
   assign io_rd    = io_sel_i & bus_i.rd;

   // One-hot addressing, several bits may be set at once
   always_comb
   begin
      io_rdata = '0;
      if (bus_i.addr[`IO_GPIO_IN_BIT])
      begin
         io_rdata = io_rdata | {{(32-`GPIO_IN_W){1'b0}}, gpio_in_i};
      end
      if (bus_i.addr[`IO_GPIO_OUT_BIT])
      begin
         io_rdata = io_rdata | gpio_o.out;
      end
      if (bus_i.addr[`IO_GPIO_DIR_BIT])
      begin
         io_rdata = io_rdata | gpio_o.dir;
      end
      if (bus_i.addr[`IO_LEDS_BIT])
      begin
         io_rdata = io_rdata | {24'd0, led_o};
      end
      if (bus_i.addr[`IO_BUTTONS_BIT])
      begin
         io_rdata = io_rdata | {{(32-`BUTTONS_W){1'b0}}, buttons_i};
      end
      if (bus_i.addr[`IO_ANALOG_BIT])
      begin
         io_rdata = io_rdata | {20'd0, analog_o};
      end
      if (bus_i.addr[`IO_TICKS_BIT])
      begin
         io_rdata = io_rdata | ticks_i;
      end
      if (bus_i.addr[`IO_RELOAD_BIT])
      begin
         io_rdata = io_rdata | reload_i;
      end
   end

   // Read-modify-write on the current contents
   always_comb
   begin
      case (mod_code)
         `MOD_WRITE:  io_mod = bus_i.wdata;
         `MOD_CLEAR:  io_mod = io_rdata & ~bus_i.wdata;
         `MOD_SET:    io_mod = io_rdata | bus_i.wdata;
         `MOD_TOGGLE: io_mod = io_rdata ^ bus_i.wdata;
         default:     io_mod = bus_i.wdata;
      endcase
   end

   always_ff @(posedge clk)
   begin
      if (mem_rstrb)
      begin
         gpio_o   <= '0;
         led_o    <= '0;
         analog_o <= '0;
         rdata_o  <= '0;
      end
      else
      begin
         // GPIO port A, byte lanes under wmask
         for (int b = 0; b < 4; b++)
         begin
            if (io_sel_i && bus_i.wmask[b] && bus_i.addr[`IO_GPIO_OUT_BIT])
            begin
               gpio_o.out[8*b +: 8] <= io_mod[8*b +: 8];
            end
            if (io_sel_i && bus_i.wmask[b] && bus_i.addr[`IO_GPIO_DIR_BIT])
            begin
               gpio_o.dir[8*b +: 8] <= io_mod[8*b +: 8];
            end
         end
         if (io_wr && bus_i.addr[`IO_LEDS_BIT])
         begin
            led_o <= io_mod[7:0]; // Whole register on any mask
         end
         if (io_wr && bus_i.addr[`IO_ANALOG_BIT])
         begin
            analog_o <= analog_t'(io_mod[11:0]);
         end
         // Capture at the strobe, bus picks it up next cycle
         if (io_rd)
         begin
            rdata_o <= io_rdata;
         end
      end
   end

endmodule

/* source/ram_store.sv */
// On-chip RAM, byte writable
`include "soc_cfg.svh"

module ram_store (
   input  logic              clk,
   input  soc_pkg::bus_req_t bus_i,
   input  logic              ram_sel_i,
   output logic [31:0]       rdata_o
);

   localparam int AW = $clog2(`RAM_WORDS); // Word index width

   logic [31:0]   mem [`RAM_WORDS];
   logic [AW-1:0] word_idx;

   // Word address, byte offset dropped
   assign word_idx = bus_i.addr[AW+1:2];

   // Byte lanes written separately
   always_ff @(posedge clk)
   begin
      for (int b = 0; b < 4; b++)
      begin
         if (ram_sel_i && bus_i.wmask[b])
         begin
            mem[word_idx][8*b +: 8] <= bus_i.wdata[8*b +: 8];
         end
      end
   end

   // Registered read, one cycle latency
   always_ff @(posedge clk)
   begin
      if (bus_i.rd)
      begin
         rdata_o <= mem[word_idx]; // Held until next strobe
      end
   end

endmodule

/* source/soc_cfg.svh */
// IO page map and memory sizes
`ifndef SOC_CFG_SVH
`define SOC_CFG_SVH

// One-hot address bits of the IO page, addr[1:0] is byte select
`define IO_GPIO_IN_BIT   4  // R   GPIO port A inputs
`define IO_GPIO_OUT_BIT  5  // RW  GPIO port A output values
`define IO_GPIO_DIR_BIT  6  // RW  GPIO port A direction, 1 drives
`define IO_LEDS_BIT      7  // RW  Eight LEDs
`define IO_BUTTONS_BIT   11 // R   Push buttons
`define IO_ANALOG_BIT    15 // RW  Three 4-bit DACs
`define IO_TICKS_BIT     18 // RW  Timer count
`define IO_RELOAD_BIT    19 // RW  Timer reload value

// Write modifier in addr[3:2]
`define MOD_WRITE        2'd0 // +0
`define MOD_CLEAR        2'd1 // +4
`define MOD_SET          2'd2 // +8
`define MOD_TOGGLE       2'd3 // +12

// Region codes from addr[31:30]
`define REGION_RAM       2'd0 // 0x0000_0000
`define REGION_IO        2'd1 // 0x4000_0000
`define REGION_FLASH     2'd2 // 0x8000_0000, reads zero
`define REGION_SDRAM     2'd3 // 0xC000_0000, reads zero

`define RAM_WORDS        1024 // 4 KB of 32-bit words
`define GPIO_IN_W        28
`define BUTTONS_W        7

`endif

/* source/soc_pkg.sv */
// Bus and peripheral types
`include "soc_cfg.svh"

package soc_pkg;

   // Processor side of the memory bus
   typedef struct packed {
      logic [31:0] addr;  // Byte address, bits 1:0 ignored
      logic [31:0] wdata;
      logic [3:0]  wmask; // One bit per byte, nonzero means write
      logic        rd;    // Read strobe
   } bus_req_t;

   // Four address regions
   typedef enum logic [1:0] {
      region_ram   = `REGION_RAM,
      region_io    = `REGION_IO,
      region_flash = `REGION_FLASH,
      region_sdram = `REGION_SDRAM
   } region_t;

   // GPIO port A output side
   typedef struct packed {
      logic [31:0] out;
      logic [31:0] dir; // 1 is output
   } gpio_t;

   // DAC channels, left channel in the low nibble
   typedef struct packed {
      logic [3:0] v; // Bits 11:8
      logic [3:0] r; // Bits 7:4
      logic [3:0] l; // Bits 3:0
   } analog_t;

endpackage

/* source/soc_top.sv */
// Memory and IO slave of the board SoC
`include "soc_cfg.svh"

module soc_top (
   input  logic                  clk,
   input  logic                  mem_rstrb,
   input  soc_pkg::bus_req_t     bus_i,
   input  logic [`GPIO_IN_W-1:0] gpio_in_i,
   input  logic [`BUTTONS_W-1:0] buttons_i,
   output logic [31:0]           rdata_o,
   output soc_pkg::gpio_t        gpio_o,
   output logic [7:0]            led_o,
   output soc_pkg::analog_t      analog_o,
   output logic                  irq_o
);

   logic        ram_sel;
   logic        io_sel;
   logic [31:0] ram_rdata; // Registered RAM word
   logic [31:0] io_rdata;  // Registered IO value
   logic [31:0] ticks;
   logic [31:0] reload;

   bus_decode u_bus_decode (
      .clk         (clk),
      .mem_rstrb   (mem_rstrb),
      .bus_i       (bus_i),
      .ram_rdata_i (ram_rdata),
      .io_rdata_i  (io_rdata),
      .ram_sel_o   (ram_sel),
      .io_sel_o    (io_sel),
      .rdata_o     (rdata_o)
   );

   ram_store u_ram_store (
      .clk       (clk),
      .bus_i     (bus_i),
      .ram_sel_i (ram_sel),
      .rdata_o   (ram_rdata)
   );

   io_regs u_io_regs (
      .clk       (clk),
      .mem_rstrb (mem_rstrb),
      .bus_i     (bus_i),
      .io_sel_i  (io_sel),
      .gpio_in_i (gpio_in_i),
      .buttons_i (buttons_i),
      .ticks_i   (ticks),
      .reload_i  (reload),
      .gpio_o    (gpio_o),
      .led_o     (led_o),
      .analog_o  (analog_o),
      .rdata_o   (io_rdata)
   );

   tick_timer u_tick_timer (
      .clk       (clk),
      .mem_rstrb (mem_rstrb),
      .bus_i     (bus_i),
      .io_sel_i  (io_sel),
      .ticks_o   (ticks),
      .reload_o  (reload),
      .irq_o     (irq_o)
   );

endmodule

/* source/tick_timer.sv */
// Tick timer with overflow interrupt
`include "soc_cfg.svh"

module tick_timer (
   input  logic              clk,
   input  logic              mem_rstrb,
   input  soc_pkg::bus_req_t bus_i,
   input  logic              io_sel_i,
   output logic [31:0]       ticks_o,
   output logic [31:0]       reload_o,
   output logic              irq_o
);

   logic [32:0] ticks_plus_1; // Carry out marks the wrap
   logic        io_wr;

   assign io_wr        = io_sel_i & (|bus_i.wmask);
   assign ticks_plus_1 = {1'b0, ticks_o} + 33'd1;

   always_ff @(posedge clk)
   begin
      if (mem_rstrb)
      begin
         ticks_o  <= '0;
         reload_o <= '0;
         irq_o    <= 1'b0;
      end
      else
      begin
         if (io_wr && bus_i.addr[`IO_TICKS_BIT])
         begin
            ticks_o <= bus_i.wdata; // Direct load wins over counting
         end
         else
         begin
            ticks_o <= ticks_plus_1[32] ? reload_o : ticks_plus_1[31:0];
         end
         if (io_wr && bus_i.addr[`IO_RELOAD_BIT])
         begin
            reload_o <= bus_i.wdata;
         end
         irq_o <= ticks_plus_1[32]; // One pulse per wrap
      end
   end

endmodule

/* test/soc_chk.sv */
// Bus and IO assertions for soc_top
`include "soc_cfg.svh"

module soc_chk (
   input logic              clk,
   input logic              mem_rstrb,
   input soc_pkg::bus_req_t bus_i,
   input logic              io_sel_i,
   input logic [31:0]       rdata_i,
   input logic [7:0]        led_i,
   input logic              irq_i
);
   timeunit 1ns;
   timeprecision 1ps;

   int fail_cnt = 0; // Failed assertions so far

   // Overflow interrupt is a single-cycle pulse
   irq_pulse: assert property (@(posedge clk) disable iff (mem_rstrb) irq_i |=> !irq_i)
      else
      begin
         fail_cnt++;
         $error("irq_o high for two cycles");
      end

   // Flash and SDRAM not fitted, read as zero
   unmapped_zero: assert property (@(posedge clk) disable iff (mem_rstrb)
      (bus_i.rd && bus_i.addr[31]) |=> (rdata_i == 32'd0))
      else
      begin
         fail_cnt++;
         $error("Nonzero read data from unmapped region");
      end

   // LEDs move only on an IO write to their bit
   led_hold: assert property (@(posedge clk) disable iff (mem_rstrb)
      !(io_sel_i && (|bus_i.wmask) && bus_i.addr[`IO_LEDS_BIT]) |=> $stable(led_i))
      else
      begin
         fail_cnt++;
         $error("led_o changed without an IO write");
      end

endmodule

bind soc_top soc_chk u_chk (
   .clk       (clk),
   .mem_rstrb (mem_rstrb),
   .bus_i     (bus_i),
   .io_sel_i  (io_sel),
   .rdata_i   (rdata_o),
   .led_i     (led_o),
   .irq_i     (irq_o)
);

/* test/soc_tb.sv */
// Testbench for the SoC memory and IO slave
`include "soc_cfg.svh"

module soc_tb;
   timeunit 1ns;
   timeprecision 1ps;
   import soc_pkg::*;

   localparam int N_RAM  = 24; // RAM words exercised
   localparam int N_GPIO = 8;  // Rounds of GPIO modifier writes
   localparam int N_OPS  = 3 * N_RAM + 4 * N_GPIO + 80;
   localparam logic [31:0] IO_BASE = 32'h4000_0000;

   logic                  clk = 1'b0;
   logic                  mem_rstrb;
   bus_req_t              bus;
   logic [`GPIO_IN_W-1:0] gpio_in;
   logic [`BUTTONS_W-1:0] buttons;
   logic [31:0]           rdata;
   gpio_t                 gpio;
   logic [7:0]            led;
   analog_t               analog;
   logic                  irq;

   // Reference state, follows the bus at every edge
   logic [31:0] m_ram [`RAM_WORDS];
   gpio_t       m_gpio;
   logic [7:0]  m_led;
   logic [11:0] m_analog;
   logic [31:0] m_ticks;
   logic [31:0] m_reload;
   logic [31:0] m_rdata;   // Held like rdata_o
   logic        m_irq;
   logic        m_rd_seen; // rdata_o defined once a read happened
   logic        checking = 1'b0;
   integer      seed = 32'hdadf_ecca;
   int          err_cnt = 0;

   soc_top u_dut (
      .clk       (clk),
      .mem_rstrb (mem_rstrb),
      .bus_i     (bus),
      .gpio_in_i (gpio_in),
      .buttons_i (buttons),
      .rdata_o   (rdata),
      .gpio_o    (gpio),
      .led_o     (led),
      .analog_o  (analog),
      .irq_o     (irq)
   );

   always #50 clk = ~clk; // 100 ns period

   function automatic logic [31:0] rnd32();
      return $random(seed);
   endfunction

   // One-hot IO register address plus modifier
   function automatic logic [31:0] io_addr(int b, logic [1:0] mod);
      return IO_BASE | (32'd1 << b) | {28'd0, mod, 2'b00};
   endfunction

   // Expected register value after a write with modifier
   function automatic logic [31:0] modify(logic [1:0] mod, logic [31:0] cur, logic [31:0] wd);
      case (mod)
         `MOD_CLEAR:  return cur & ~wd;
         `MOD_SET:    return cur | wd;
         `MOD_TOGGLE: return cur ^ wd;
         default:     return wd;
      endcase
   endfunction

   // Expected IO read, OR of every addressed register
   function automatic logic [31:0] io_read(logic [31:0] a);
      logic [31:0] v;
      v = '0;
      if (a[`IO_GPIO_IN_BIT])  v = v | 32'(gpio_in);
      if (a[`IO_GPIO_OUT_BIT]) v = v | m_gpio.out;
      if (a[`IO_GPIO_DIR_BIT]) v = v | m_gpio.dir;
      if (a[`IO_LEDS_BIT])     v = v | {24'd0, m_led};
      if (a[`IO_BUTTONS_BIT])  v = v | 32'(buttons);
      if (a[`IO_ANALOG_BIT])   v = v | {20'd0, m_analog};
      if (a[`IO_TICKS_BIT])    v = v | m_ticks;
      if (a[`IO_RELOAD_BIT])   v = v | m_reload;
      return v;
   endfunction

   task automatic check_value(string name, logic [63:0] got, logic [63:0] exp);
      if (got !== exp)
      begin
         err_cnt++;
         $display("ERROR t=%0t %s got %h expected %h", $time, name, got, exp);
         $display("Checks failed");
         $fatal(1, "Mismatch on %s", name);
      end
   endtask

   // One bus cycle, returns 5 ns after the edge that takes it
   task automatic bus_op(logic [31:0] a, logic [31:0] wd, logic [3:0] wm, logic rd_en);
      bus = '{addr: a, wdata: wd, wmask: wm, rd: rd_en};
      @(posedge clk);
      #5;
      bus = '0;
   endtask

   // Reference model, all next values from the state before the edge
   always @(posedge clk)
   begin : ref_model
      logic [31:0] cur;
      logic [31:0] nxt;
      logic        io_wr;
      io_wr = (bus.addr[31:30] == `REGION_IO) && (|bus.wmask);
      cur   = io_read(bus.addr);
      nxt   = modify(bus.addr[3:2], cur, bus.wdata);
      if (mem_rstrb)
      begin
         m_gpio    = '0;
         m_led     = '0;
         m_analog  = '0;
         m_ticks   = '0;
         m_reload  = '0;
         m_irq     = 1'b0;
         m_rd_seen = 1'b0;
      end
      else
      begin
         if (bus.rd)
         begin
            m_rd_seen = 1'b1;
            case (bus.addr[31:30])
               `REGION_RAM: m_rdata = m_ram[bus.addr[11:2]];
               `REGION_IO:  m_rdata = cur;
               default:     m_rdata = '0; // Flash, SDRAM
            endcase
         end
         for (int b = 0; b < 4; b++)
         begin
            if (bus.addr[31:30] == `REGION_RAM && bus.wmask[b])
               m_ram[bus.addr[11:2]][8*b +: 8] = bus.wdata[8*b +: 8];
            if (io_wr && bus.wmask[b] && bus.addr[`IO_GPIO_OUT_BIT])
               m_gpio.out[8*b +: 8] = nxt[8*b +: 8];
            if (io_wr && bus.wmask[b] && bus.addr[`IO_GPIO_DIR_BIT])
               m_gpio.dir[8*b +: 8] = nxt[8*b +: 8];
         end
         if (io_wr && bus.addr[`IO_LEDS_BIT])   m_led = nxt[7:0];     // Whole byte
         if (io_wr && bus.addr[`IO_ANALOG_BIT]) m_analog = nxt[11:0];
         m_irq = (m_ticks == '1); // Wrap next
         if (io_wr && bus.addr[`IO_TICKS_BIT])
            m_ticks = bus.wdata;  // No modifier on the timer
         else
            m_ticks = m_irq ? m_reload : m_ticks + 32'd1;
         if (io_wr && bus.addr[`IO_RELOAD_BIT]) m_reload = bus.wdata;
      end
   end

   // Outputs settled by the falling edge
   always @(negedge clk)
   begin
      if (checking)
      begin
         check_value("led_o", {56'd0, led}, {56'd0, m_led});
         check_value("gpio_o", gpio, m_gpio);
         check_value("analog_o", {52'd0, analog}, {52'd0, m_analog});
         check_value("irq_o", {63'd0, irq}, {63'd0, m_irq});
         if (m_rd_seen) check_value("rdata_o", {32'd0, rdata}, {32'd0, m_rdata});
      end
   end

   initial
   begin : stimulus
      logic [31:0] a;
      logic [31:0] r;
      int          n;
      mem_rstrb = 1'b1;
      bus       = '0;
      gpio_in   = '0;
      buttons   = '0;
      repeat (3) @(posedge clk);
      #5;
      mem_rstrb = 1'b0;
      checking  = 1'b1;
      // Registers read zero out of reset
      bus_op(io_addr(`IO_LEDS_BIT, `MOD_WRITE), 32'd0, 4'd0, 1'b1);
      bus_op(io_addr(`IO_GPIO_OUT_BIT, `MOD_WRITE), 32'd0, 4'd0, 1'b1);
      bus_op(io_addr(`IO_GPIO_DIR_BIT, `MOD_WRITE), 32'd0, 4'd0, 1'b1);
      bus_op(io_addr(`IO_ANALOG_BIT, `MOD_WRITE), 32'd0, 4'd0, 1'b1);
      // RAM, full word first so no byte stays undefined
      for (int i = 0; i < N_RAM; i++)
      begin
         r = rnd32();
         a = {20'd0, r[9:0], 2'b00};
         bus_op(a, rnd32(), 4'hf, 1'b0);
         r = rnd32();
         bus_op(a, rnd32(), r[3:0], 1'b0); // Random byte mask
         bus_op(a, 32'd0, 4'd0, 1'b1);
      end
      // GPIO out and dir, every modifier code
      for (int i = 0; i < N_GPIO; i++)
      begin
         r = rnd32();
         bus_op(io_addr(`IO_GPIO_OUT_BIT, 2'(i)), rnd32(), r[3:0], 1'b0);
         bus_op(io_addr(`IO_GPIO_DIR_BIT, 2'(i)), rnd32(), r[7:4], 1'b0);
         bus_op(io_addr(`IO_GPIO_OUT_BIT, `MOD_WRITE), 32'd0, 4'd0, 1'b1);
         bus_op(io_addr(`IO_GPIO_DIR_BIT, `MOD_WRITE), 32'd0, 4'd0, 1'b1);
      end
      // LEDs, analog and input ports
      for (int i = 0; i < 4; i++)
      begin
         r = rnd32();
         gpio_in = r[`GPIO_IN_W-1:0];
         r = rnd32();
         buttons = r[`BUTTONS_W-1:0];
         bus_op(io_addr(`IO_LEDS_BIT, 2'(i)), rnd32(), 4'h1, 1'b0);
         bus_op(io_addr(`IO_ANALOG_BIT, 2'(i)), rnd32(), 4'h3, 1'b0);
         bus_op(io_addr(`IO_GPIO_IN_BIT, `MOD_WRITE), 32'd0, 4'd0, 1'b1);
         bus_op(io_addr(`IO_BUTTONS_BIT, `MOD_WRITE), 32'd0, 4'd0, 1'b1);
         bus_op(io_addr(`IO_LEDS_BIT, `MOD_WRITE), 32'd0, 4'd0, 1'b1);
      end
      // Timer wrap 16 edges after the load
      bus_op(io_addr(`IO_RELOAD_BIT, `MOD_WRITE), rnd32(), 4'hf, 1'b0);
      bus_op(io_addr(`IO_TICKS_BIT, `MOD_WRITE), 32'hFFFF_FFF0, 4'hf, 1'b0);
      n = 0;
      do
      begin
         @(posedge clk);
         n++;
         @(negedge clk);
      end
      while (irq !== 1'b1 && n < 40);
      check_value("irq_o edge count", 64'(n), 64'd16);
      @(posedge clk);
      #5;
      repeat (3) bus_op(32'd0, 32'd0, 4'd0, 1'b0);
      bus_op(io_addr(`IO_TICKS_BIT, `MOD_WRITE), 32'd0, 4'd0, 1'b1);
      // Flash and SDRAM, read zero and drop writes
      for (int i = 0; i < 8; i++)
      begin
         r = rnd32();
         a = {(i[0] ? 2'b11 : 2'b10), r[29:0]};
         bus_op(a, rnd32(), 4'hf, 1'b0);
         bus_op(a, 32'd0, 4'd0, 1'b1);
         bus_op({20'd0, a[11:2], 2'b00}, 32'd0, 4'd0, 1'b1); // Same RAM word untouched
      end
      bus_op(32'd0, 32'd0, 4'd0, 1'b0);
      if (err_cnt == 0 && u_dut.u_chk.fail_cnt == 0)
      begin
         $display("All checks passed");
         $finish;
      end
      else
      begin
         $display("Assertion failures seen in soc_chk");
         $display("Checks failed");
         $fatal(1, "Run ended with failures");
      end
   end

   // Watchdog sized from the operation count
   initial
   begin
      #((N_OPS + 100) * 100);
      $display("Timeout, run did not end within %0d cycles", N_OPS + 100);
      $display("Checks failed");
      $fatal(1, "Watchdog expired");
   end

endmodule
